// ==== all.f ====
+incdir+tests
source/stim_cfg_pkg.sv
source/stim_types_pkg.sv
source/stim_stream_if.sv
source/stim_channel.sv
source/stim_merge.sv
source/stim_top.sv
tests/stim_tb.sv

// ==== tests/stim_tb_checks.svh ====
// reference model, expected queues and typed compare tasks for the testbench
// included inside the testbench module, uses its word type and sizes
`ifndef STIM_TB_CHECKS_SVH
`define STIM_TB_CHECKS_SVH

word_t exp_a[$]; // expected words, lane A
word_t exp_b[$]; // expected words, lane B

// error line and failure banner before the stop
task automatic stop_on_error(input string what);
   $display("%s", what);
   $display("Test failures found");
   $fatal(1, "run stopped at the first error");
endtask

// ############################
// reference model
// ############################

// a lane sends its words in load order up to the first clear valid bit
function automatic void build_expected(input word_t words[$], input stim_types_pkg::lane_t ln);
   stim_types_pkg::stim_ctrl_t ctrl;
   bit                         ended;
   ended = 1'b0;
   for (int i = 0; i < words.size(); i++)
   begin
      ctrl  = words[i][stim_cfg_pkg::ctrl_w-1:0];
      ended = ended || !ctrl.entry_valid; // nothing after the marker
      if (!ended && ln == stim_types_pkg::lane_id_a)
         exp_a.push_back(words[i]);
      else if (!ended)
         exp_b.push_back(words[i]);
   end
endfunction

// ############################
// compare tasks
// ############################

task automatic check_packet(input logic [packet_w-1:0] got, input logic [packet_w-1:0] want);
   if (got !== want)
      stop_on_error($sformatf("CHECK FAILED at %0t: out_packet got %h expected %h",
                              $time, got, want));
endtask

task automatic check_lane(input stim_types_pkg::lane_t got, input stim_types_pkg::lane_t want);
   if (got !== want)
      stop_on_error($sformatf("CHECK FAILED at %0t: out_lane got %b expected %b",
                              $time, got, want));
endtask

task automatic check_done(input logic got, input bit want);
   if (got !== want)
      stop_on_error($sformatf("CHECK FAILED at %0t: out_done got %b expected %b",
                              $time, got, want));
endtask

task automatic check_valid(input logic got, input bit want);
   if (got !== want)
      stop_on_error($sformatf("CHECK FAILED at %0t: out_valid got %b expected %b",
                              $time, got, want));
endtask

`endif

// ==== tests/stim_tb.sv ====
// testbench for the two-lane stimulus player
// loads both lanes, pulses go and checks the merged stream against a reference
`timescale 1ns/1ps
`default_nettype none

module stim_tb;

   localparam int packet_w = stim_cfg_pkg::packet_w_default;
   localparam int depth    = stim_cfg_pkg::depth_default;
   localparam int word_w   = packet_w + stim_cfg_pkg::ctrl_w;

   typedef logic [word_w-1:0] word_t; // packet over control

   logic                  dut_clk;
   logic                  ext_clk;
   logic                  nreset;
   logic                  load;
   logic                  ext_valid;
   stim_types_pkg::lane_t ext_lane;
   word_t                 ext_word;
   logic                  go;
   logic                  dut_ready;
   logic                  out_valid;
   logic [packet_w-1:0]   out_packet;
   stim_types_pkg::lane_t out_lane;
   logic                  out_done;

   integer seed;
   word_t  words_a[$];    // loaded list, marker and junk included
   word_t  words_b[$];
   bit     go_sent;
   bit     ready_random;  // random back-pressure on
   bit     spacing_check; // delay spacing checked
   bit     rr_check;      // alternation checked
   bit     single_lane;   // lane B holds only its marker
   int     limit;         // timeout of the running test
   int     run_cycles;
   int     cyc;

   // compare process state
   logic [packet_w-1:0]   held_packet;
   stim_types_pkg::lane_t held_lane;
   bit                    stall;
   bit                    done_seen;
   bit                    seen_any;
   int                    prev_lane;
   bit                    seen_lane[2];
   int                    last_xfer[2];
   int                    last_delay[2];

   `include "stim_tb_checks.svh"

   stim_top #(
      .PACKET_W (packet_w),
      .DEPTH    (depth)
   ) u_stim_top (
      .dut_clk    (dut_clk),
      .ext_clk    (ext_clk),
      .nreset     (nreset),
      .load       (load),
      .ext_valid  (ext_valid),
      .ext_lane   (ext_lane),
      .ext_word   (ext_word),
      .go         (go),
      .dut_ready  (dut_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_lane   (out_lane),
      .out_done   (out_done)
   );

   // ##############################
   // clocks and back-pressure
   // ##############################

   initial dut_clk = 1'b0;
   always #10 dut_clk = ~dut_clk; // 20 ns

   initial ext_clk = 1'b0;
   always #13 ext_clk = ~ext_clk; // loader clock, never on a dut_clk edge

   always @(posedge dut_clk)
   begin
      dut_ready <= ready_random ? (($random(seed) & 3) != 0) : 1'b1; // ready 3 in 4
   end

   // ##############################
   // stimulus tasks
   // ##############################

   task automatic reset_dut();
      @(posedge dut_clk);
      nreset  <= 1'b0;
      go      <= 1'b0;
      go_sent <= 1'b0;
      repeat (3) @(posedge dut_clk);
      nreset  <= 1'b1;
   endtask

   // n real entries, end marker at n, two valid junk words behind it
   task automatic make_words(ref word_t words[$], input int n, input int max_delay);
      stim_types_pkg::stim_ctrl_t ctrl;
      words.delete();
      for (int i = 0; i < n + 3; i++)
      begin
         ctrl.delay       = $unsigned($random(seed)) % (max_delay + 1);
         ctrl.entry_valid = (i != n);
         words.push_back({$random(seed), $random(seed), ctrl});
         limit = limit + ctrl.delay + 4; // timeout budget per entry
      end
   endtask

   task automatic load_words(input word_t words[$], input stim_types_pkg::lane_t ln);
      for (int i = 0; i < words.size(); i++)
      begin
         @(posedge ext_clk);
         load      <= 1'b1;
         ext_valid <= 1'b1;
         ext_lane  <= ln;
         ext_word  <= words[i];
         if (($random(seed) & 7) == 0)
         begin
            @(posedge ext_clk);
            ext_valid <= 1'b0; // idle gap now and then
         end
      end
      @(posedge ext_clk);
      load      <= 1'b0;
      ext_valid <= 1'b0;
   endtask

   task automatic run_lanes(input int len_a, input int len_b, input int max_delay,
                            input bit rand_ready, input bit spacing, input bit rr);
      reset_dut();
      limit = 20;
      make_words(words_a, len_a, max_delay);
      make_words(words_b, len_b, max_delay);
      build_expected(words_a, stim_types_pkg::lane_id_a);
      build_expected(words_b, stim_types_pkg::lane_id_b);
      load_words(words_a, stim_types_pkg::lane_id_a);
      load_words(words_b, stim_types_pkg::lane_id_b);
      @(posedge dut_clk);
      ready_random  <= rand_ready;
      spacing_check <= spacing;
      rr_check      <= rr;
      single_lane   <= (len_b == 0);
      repeat (4) @(posedge dut_clk); // loaded but idle, out_valid must stay low
      go      <= 1'b1;
      go_sent <= 1'b1;
      @(posedge dut_clk);
      go <= 1'b0;
      while (out_done !== 1'b1)
         @(posedge dut_clk); // timeout lives in the compare process
      if (exp_a.size() != 0 || exp_b.size() != 0)
         stop_on_error("out_done rose while packets were still expected");
      repeat (3) @(posedge dut_clk); // done has to hold
   endtask

   // ##############################
   // compare process
   // ##############################

   task automatic take_packet();
      word_t                      want;
      stim_types_pkg::stim_ctrl_t ctrl;
      int                         lane;
      lane = out_lane;
      if (single_lane)
         check_lane(out_lane, stim_types_pkg::lane_id_a);
      if ((lane == 0 && exp_a.size() == 0) || (lane == 1 && exp_b.size() == 0))
         stop_on_error($sformatf("lane %0d sent a packet that was never expected", lane));
      if (lane == 0)
         want = exp_a.pop_front();
      else
         want = exp_b.pop_front();
      check_packet(out_packet, want[word_w-1:stim_cfg_pkg::ctrl_w]);
      if (spacing_check && seen_lane[lane] && (cyc - last_xfer[lane]) < last_delay[lane] + 1)
         stop_on_error($sformatf("CHECK FAILED at %0t: lane %0d spacing got %0d expected %0d",
                                 $time, lane, cyc - last_xfer[lane], last_delay[lane] + 1));
      if (rr_check && seen_any && lane == prev_lane &&
          ((lane == 0) ? exp_b.size() : exp_a.size()) != 0)
         stop_on_error($sformatf("lane %0d won twice in a row while the other lane waited", lane));
      ctrl             = want[stim_cfg_pkg::ctrl_w-1:0];
      seen_lane[lane]  = 1'b1;
      last_xfer[lane]  = cyc;
      last_delay[lane] = ctrl.delay;
      prev_lane        = lane;
      seen_any         = 1'b1;
   endtask

   always @(posedge dut_clk)
   begin
      if (!nreset)
      begin
         done_seen    = 1'b0;
         stall        = 1'b0;
         seen_any     = 1'b0;
         seen_lane[0] = 1'b0;
         seen_lane[1] = 1'b0;
         run_cycles   = 0;
      end
      else
      begin
         if (!go_sent)
            check_valid(out_valid, 1'b0); // nothing leaves before go
         if (exp_a.size() != 0 || exp_b.size() != 0)
            check_done(out_done, 1'b0);
         if (done_seen)
            check_done(out_done, 1'b1); // sticky until reset
         if (stall)
         begin
            check_valid(out_valid, 1'b1);
            check_packet(out_packet, held_packet);
            check_lane(out_lane, held_lane);
         end
         if (out_valid && dut_ready)
            take_packet();
         if (go_sent && !out_done)
            run_cycles++;
         if (run_cycles > limit)
            stop_on_error($sformatf("timeout, out_done not seen within %0d cycles of go", limit));
         done_seen   = done_seen || out_done;
         stall       = out_valid && !dut_ready;
         held_packet = out_packet;
         held_lane   = out_lane;
      end
      cyc++;
   end

   // ##############################
   // main sequence
   // ##############################

   initial
   begin
      int len_a;
      int len_b;
      seed          = 32'hdfd4b4d4;
      limit         = 20;
      cyc           = 0;
      run_cycles    = 0;
      nreset        <= 1'b0;
      load          <= 1'b0;
      ext_valid     <= 1'b0;
      ext_lane      <= stim_types_pkg::lane_id_a;
      ext_word      <= '0;
      go            <= 1'b0;
      dut_ready     <= 1'b1;
      go_sent       <= 1'b0;
      ready_random  <= 1'b0;
      spacing_check <= 1'b0;
      rr_check      <= 1'b0;
      single_lane   <= 1'b0;
      len_a = 4 + $unsigned($random(seed)) % 9;
      len_b = 4 + $unsigned($random(seed)) % 9;

      run_lanes(len_a, len_b, 5, 1'b1, 1'b0, 1'b0);     // mixed delays, random stalls
      run_lanes(len_a + 2, 0, 5, 1'b0, 1'b1, 1'b0);     // lane B empty, delay spacing
      run_lanes(len_a, len_b, 0, 1'b0, 1'b1, 1'b1);     // zero delays, alternation

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/stim_top.sv ====
// two-lane stimulus player, the block the testbench instantiates
// load both lanes on ext_clk, pulse go, collect packets at out_*
`timescale 1ns/1ps
`default_nettype none

module stim_top #(
   parameter int PACKET_W = stim_cfg_pkg::packet_w_default,
   parameter int DEPTH    = stim_cfg_pkg::depth_default
) (
   input  logic                                   dut_clk,
   input  logic                                   ext_clk,   // loader clock
   input  logic                                   nreset,    // async, active low
   input  logic                                   load,      // loading window
   input  logic                                   ext_valid, // word on ext_word
   input  stim_types_pkg::lane_t                  ext_lane,  // target lane
   input  logic [PACKET_W+stim_cfg_pkg::ctrl_w-1:0] ext_word,  // packet over control
   input  logic                                   go,        // start replay
   input  logic                                   dut_ready,
   output logic                                   out_valid,
   output logic [PACKET_W-1:0]                    out_packet,
   output stim_types_pkg::lane_t                  out_lane,
   output logic                                   out_done
);

   // ############################
   // lane streams
   // ############################

   stim_stream_if #(.PACKET_W(PACKET_W)) lane_a ();
   stim_stream_if #(.PACKET_W(PACKET_W)) lane_b ();

   logic wr_en_a;
   logic wr_en_b;

   // lane select for the loader
   assign wr_en_a = load && ext_valid && (ext_lane == stim_types_pkg::lane_id_a);
   assign wr_en_b = load && ext_valid && (ext_lane == stim_types_pkg::lane_id_b);

   // ############################
   // channels and merge
   // ############################

   stim_channel #(
      .PACKET_W (PACKET_W),
      .DEPTH    (DEPTH)
   ) u_channel_a (
      .nreset  (nreset),
      .ext_clk (ext_clk),
      .dut_clk (dut_clk),
      .wr_en   (wr_en_a),
      .wr_word (ext_word),
      .go      (go),
      .stream  (lane_a.source)
   );

   stim_channel #(
      .PACKET_W (PACKET_W),
      .DEPTH    (DEPTH)
   ) u_channel_b (
      .nreset  (nreset),
      .ext_clk (ext_clk),
      .dut_clk (dut_clk),
      .wr_en   (wr_en_b),
      .wr_word (ext_word),
      .go      (go),
      .stream  (lane_b.source)
   );

   stim_merge #(
      .PACKET_W (PACKET_W)
   ) u_merge (
      .dut_clk    (dut_clk),
      .nreset     (nreset),
      .lane_a     (lane_a.sink),
      .lane_b     (lane_b.sink),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_lane   (out_lane),
      .out_ready  (dut_ready),
      .out_done   (out_done)
   );

endmodule

`default_nettype wire

// ==== source/stim_merge.sv ====
// round-robin merge of the two lane streams into one tagged output
// also raises the overall done flag once everything has left
`timescale 1ns/1ps
`default_nettype none

module stim_merge #(
   parameter int PACKET_W = stim_cfg_pkg::packet_w_default
) (
   input  logic                  dut_clk,
   input  logic                  nreset,     // async, active low
   stim_stream_if.sink           lane_a,
   stim_stream_if.sink           lane_b,
   output logic                  out_valid,  // toward the DUT
   output logic [PACKET_W-1:0]   out_packet,
   output stim_types_pkg::lane_t out_lane,   // which lane sent it
   input  logic                  out_ready,  // DUT back-pressure
   output logic                  out_done    // all lanes finished and drained
);

   // ############################
   // declarations
   // ############################

   stim_types_pkg::lane_t rr_ptr; // lane that wins a tie

   logic reg_free; // output register empty or draining
   logic pick_b;   // lane B wins arbitration
   logic grant_a;
   logic grant_b;
   logic grant;

   // ############################
   // arbitration
   // ############################

   assign reg_free = !out_valid || out_ready;

   // lane B when alone, or when both are up and it is B's turn
   assign pick_b = lane_b.valid &&
                   (!lane_a.valid || (rr_ptr == stim_types_pkg::lane_id_b));

   assign grant_a = reg_free && lane_a.valid && !pick_b;
   assign grant_b = reg_free && pick_b;
   assign grant   = grant_a || grant_b;

   // ready back to the lanes, low while the DUT stalls a full register
   assign lane_a.ready = grant_a;
   assign lane_b.ready = grant_b;

   // pointer moves to the other lane after each grant
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         rr_ptr <= stim_types_pkg::lane_id_a;
      else if (grant)
         rr_ptr <= grant_a ? stim_types_pkg::lane_id_b
                           : stim_types_pkg::lane_id_a;
   end

   // ############################
   // output register
   // ############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         out_valid <= 1'b0;
      else if (grant)
         out_valid <= 1'b1;
      else if (out_ready)
         out_valid <= 1'b0; // drained, nothing new
   end

   // payload, held while out_ready is low
   always_ff @(posedge dut_clk)
   begin
      if (grant)
      begin
         out_packet <= pick_b ? lane_b.packet : lane_a.packet;
         out_lane   <= pick_b ? stim_types_pkg::lane_id_b
                              : stim_types_pkg::lane_id_a;
      end
   end

   // ############################
   // done
   // ############################

   // lane done levels never fall and a done lane never sends,
   // so this stays high once reached
   assign out_done = lane_a.done && lane_b.done && !out_valid;

endmodule

`default_nettype wire

// ==== source/stim_channel.sv ====
// one stimulus lane, loaded on ext_clk and replayed on dut_clk
// entries leave through a valid/ready stream, the end marker stops the lane
`timescale 1ns/1ps
`default_nettype none

module stim_channel #(
   parameter int PACKET_W = stim_cfg_pkg::packet_w_default,
   parameter int DEPTH    = stim_cfg_pkg::depth_default
) (
   input  logic                                   nreset,  // async, active low
   input  logic                                   ext_clk, // loader clock
   input  logic                                   dut_clk, // replay clock
   input  logic                                   wr_en,   // already lane decoded
   input  logic [PACKET_W+stim_cfg_pkg::ctrl_w-1:0] wr_word, // packet over control
   input  logic                                   go,      // start, async to dut_clk
   stim_stream_if.source                          stream
);

   localparam int word_w = PACKET_W + stim_cfg_pkg::ctrl_w;
   localparam int addr_w = $clog2(DEPTH);

   // ############################
   // declarations
   // ############################

   logic [word_w-1:0] ram [0:DEPTH-1]; // dual clock entry store

   logic [addr_w-1:0] wr_addr;     // ext_clk side
   logic [addr_w-1:0] rd_addr;     // next entry to present
   logic [addr_w-1:0] rd_addr_nxt; // address into the read port
   logic [word_w-1:0] mem_data;    // read port output, one cycle latency

   stim_types_pkg::stim_ctrl_t mem_ctrl; // control of the fetched entry
   stim_types_pkg::seq_state_t state;

   logic [1:0] go_sync_q; // two flop synchronizer
   logic       go_sync;
   logic       primed;    // mem_data holds ram[rd_addr]

   logic [stim_cfg_pkg::ctrl_w-2:0] out_delay; // delay of the presented entry
   logic [stim_cfg_pkg::ctrl_w-2:0] pause_cnt;

   logic slot_free;   // output register empty or draining
   logic xfer;        // stream transfer this cycle
   logic pause_start; // transfer of an entry with nonzero delay
   logic fetch_step;  // fetched entry gets consumed this cycle
   logic take_entry;  // real entry moves into the output register
   logic end_seen;    // end marker reached

   // ############################
   // write side, ext_clk
   // ############################

   // write counter, restarts at zero after reset
   always_ff @(posedge ext_clk or negedge nreset)
   begin
      if (!nreset)
         wr_addr <= '0;
      else if (wr_en)
         wr_addr <= wr_addr + 1'b1;
   end

   always_ff @(posedge ext_clk)
   begin
      if (wr_en)
         ram[wr_addr] <= wr_word;
   end

   // ############################
   // go into dut_clk domain
   // ############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         go_sync_q <= 2'b00;
      else
         go_sync_q <= {go_sync_q[0], go};
   end

   assign go_sync = go_sync_q[1];

   // ############################
   // read port
   // ############################

   // reads the address rd_addr will hold after this edge,
   // so the next entry is ready right behind the presented one
   assign rd_addr_nxt = take_entry ? rd_addr + 1'b1 : rd_addr;

   always_ff @(posedge dut_clk)
   begin
      mem_data <= ram[rd_addr_nxt];
   end

   assign mem_ctrl = mem_data[stim_cfg_pkg::ctrl_w-1:0];

   // ############################
   // replay control
   // ############################

   assign slot_free   = !stream.valid || stream.ready;
   assign xfer        = stream.valid && stream.ready;
   assign pause_start = xfer && (out_delay != '0);

   // consume the fetched entry when active with room,
   // or on the last pause cycle
   assign fetch_step = primed &&
                       (((state == stim_types_pkg::seq_active) && slot_free && !pause_start) ||
                        ((state == stim_types_pkg::seq_pause) && (pause_cnt == '0)));

   assign take_entry = fetch_step && mem_ctrl.entry_valid;
   assign end_seen   = fetch_step && !mem_ctrl.entry_valid;

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state        <= stim_types_pkg::seq_idle;
         rd_addr      <= '0;
         pause_cnt    <= '0;
         primed       <= 1'b0;
         stream.valid <= 1'b0;
      end
      else
      begin
         // one read cycle after go before the first fetch counts
         primed  <= (state == stim_types_pkg::seq_active) ||
                    (state == stim_types_pkg::seq_pause);
         rd_addr <= rd_addr_nxt; // moves only with take_entry

         case (state)
            stim_types_pkg::seq_idle:
            begin
               if (go_sync)
                  state <= stim_types_pkg::seq_active;
            end
            stim_types_pkg::seq_active:
            begin
               if (pause_start)
               begin
                  state     <= stim_types_pkg::seq_pause;
                  pause_cnt <= out_delay - 1'b1; // delay d gives d empty cycles
               end
               else if (end_seen)
                  state <= stim_types_pkg::seq_done;
            end
            stim_types_pkg::seq_pause:
            begin
               if (pause_cnt == '0)
                  state <= end_seen ? stim_types_pkg::seq_done
                                    : stim_types_pkg::seq_active;
               else
                  pause_cnt <= pause_cnt - 1'b1;
            end
            default:
               state <= stim_types_pkg::seq_done; // terminal
         endcase

         // output valid, set on load, cleared after transfer
         if (take_entry)
            stream.valid <= 1'b1;
         else if (xfer)
            stream.valid <= 1'b0;
      end
   end

   // output payload, stays put while stalled
   always_ff @(posedge dut_clk)
   begin
      if (take_entry)
      begin
         stream.packet <= mem_data[word_w-1:stim_cfg_pkg::ctrl_w];
         out_delay     <= mem_ctrl.delay;
      end
   end

   assign stream.done = (state == stim_types_pkg::seq_done);

endmodule

`default_nettype wire

// ==== source/stim_stream_if.sv ====
// valid/ready packet stream between a lane and the merge
// transfer on any dut_clk edge with valid and ready both high
`timescale 1ns/1ps
`default_nettype none

interface stim_stream_if #(
   parameter int PACKET_W = stim_cfg_pkg::packet_w_default
) ();

   logic                valid;  // packet on the bus
   logic                ready;  // sink can take it
   logic [PACKET_W-1:0] packet; // held stable until transfer
   logic                done;   // level, source will never send again

   // lane side
   modport source (
      output valid,
      output packet,
      output done,
      input  ready
   );

   // merge side
   modport sink (
      input  valid,
      input  packet,
      input  done,
      output ready
   );

endinterface

`default_nettype wire

// ==== source/stim_types_pkg.sv ====
// shared types for the stimulus player
// control field layout, lane tag and replay FSM states
`default_nettype none

package stim_types_pkg;

   // ############################
   // control field of a stored word
   // ############################

   // bit 0 marks a real entry, clear means end of list
   typedef struct packed {
      logic [stim_cfg_pkg::ctrl_w-2:0] delay;       // idle cycles after transfer
      logic                            entry_valid; // 0 = end marker
   } stim_ctrl_t;

   // ############################
   // lane tag
   // ############################

   typedef logic lane_t;

   localparam lane_t lane_id_a = 1'b0; // lane A
   localparam lane_t lane_id_b = 1'b1; // lane B

   // ############################
   // replay FSM
   // ############################

   typedef enum logic [1:0] {
      seq_idle   = 2'b00, // waiting for go
      seq_active = 2'b01, // fetching and presenting entries
      seq_pause  = 2'b10, // counting down an entry delay
      seq_done   = 2'b11  // end marker seen, never sends again
   } seq_state_t;

endpackage

`default_nettype wire

// ==== source/stim_cfg_pkg.sv ====
// size defaults for the stimulus player
// stim_top takes its parameter defaults from here and passes them down
`default_nettype none

package stim_cfg_pkg;

   // ############################
   // stream and memory sizing
   // ############################

   // packet width in bits, upper part of each stored word
   parameter int packet_w_default = 64;

   // entries per lane memory
   parameter int depth_default = 256; // power of two keeps address wrap clean

   // ############################
   // stored word format
   // ############################

   // control field in the low bits of every stored word
   // fixed format, the delay and valid bit live here
   parameter int ctrl_w = 8;

endpackage

`default_nettype wire
